// ==== rtl/arrayPkg.sv ====
// Widths, action codes and error codes shared by the array memory pipeline.
// Modules take these with a wildcard import of arrayPkg in their header.
package arrayPkg;

  //--------------------------------------------------------------------------
  // Sizes
  //--------------------------------------------------------------------------
  localparam int addressBits = 3;                 // Bits in an array number
  localparam int indexBits   = 3;                 // Bits in an element index
  localparam int dataBits    = 16;                // Width of one element
  localparam int arrays      = 1 << addressBits;  // Number of arrays
  localparam int arrayLength = 1 << indexBits;    // Elements per array
  localparam int sizeBits    = indexBits + 1;     // Size can reach arrayLength
  localparam int countBits   = addressBits + 1;   // Count of arrays handed out
  localparam int slots       = arrays * arrayLength;  // Words of element storage

  //--------------------------------------------------------------------------
  // Request encodings
  //--------------------------------------------------------------------------
  typedef enum logic [7:0] {
    actWrite    = 8'd2,   // Write an element
    actRead     = 8'd3,   // Read an element
    actSize     = 8'd4,   // Size of array
    actInc      = 8'd5,   // Grow by one
    actDec      = 8'd6,   // Shrink by one
    actPush     = 8'd14,  // Append at the end
    actPop      = 8'd15,  // Remove from the end
    actResize   = 8'd17,  // Set size from dataIn
    actAlloc    = 8'd18,  // Hand out an array
    actFree     = 8'd19,  // Take an array back
    actAdd      = 8'd20,  // Add, return new value
    actAddAfter = 8'd21,  // Add, return old value
    actSubtract = 8'd22,  // Subtract, return new value
    actSubAfter = 8'd23,  // Subtract, return old value
    actOr       = 8'd28,
    actXor      = 8'd29,
    actAnd      = 8'd30
  } actionT;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,  // Never handed out
    errFreed        = 3'd2,  // Handed out then freed
    errBounds       = 3'd3,  // Index or new size too large
    errFull         = 3'd4,
    errEmpty        = 3'd5,
    errOutOfMemory  = 3'd6,
    errBadAction    = 3'd7
  } errorT;

  // Work done on the element word in stage 2
  typedef enum logic [2:0] {
    opNone, opStore, opLoad, opAdd, opSub, opOr, opXor, opAnd
  } elemOpT;

endpackage

// ==== rtl/heapAllocator.sv ====
// Hands out array numbers, reusing freed ones before never-used ones.
// Answers combinationally, updates on the clock edge of an allocate or release.
`timescale 1ns/1ns

module heapAllocator import arrayPkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   allocate,      // Take nextArray
  input  logic                   releaseReq,    // Give back releaseArray
  input  logic [addressBits-1:0] releaseArray,
  output logic                   canAllocate,
  output logic [addressBits-1:0] nextArray,
  output logic [countBits-1:0]   newCount       // Arrays handed out so far
);

  logic [addressBits-1:0] freedStack [arrays];  // Freed array numbers
  logic [countBits-1:0]   stackTop;             // Entries on the stack
  logic [addressBits-1:0] topIndex;             // Slot of the top entry
  logic                   stackEmpty;

  assign stackEmpty  = stackTop == '0;
  assign topIndex    = addressBits'(stackTop - 1'b1);
  assign nextArray   = stackEmpty ? newCount[addressBits-1:0] : freedStack[topIndex];
  assign canAllocate = !stackEmpty || newCount != countBits'(arrays);

  always_ff @(posedge clock) begin
    if (reset) begin
      stackTop <= '0;
      newCount <= '0;
    end else if (allocate) begin
      if (stackEmpty) newCount <= newCount + 1'b1;  // Fresh array
      else stackTop <= stackTop - 1'b1;             // Reuse last freed
    end else if (releaseReq) begin
      stackTop <= stackTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (releaseReq) freedStack[stackTop[addressBits-1:0]] <= releaseArray;  // Push
  end

  // Double frees are rejected upstream, so the stack can never fill past arrays
  assert property (@(posedge clock) disable iff (reset)
    releaseReq |-> stackTop < countBits'(arrays));

endmodule

// ==== rtl/requestCheck.sv ====
// Stage 1 of the array memory. Checks each request against the allocation
// and size tables, applies size changes, and registers the element work.
`timescale 1ns/1ns

module requestCheck import arrayPkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start,
  input  actionT                 action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  output logic                   opValid,      // Request in stage 2
  output elemOpT                 elemOp,
  output logic [addressBits-1:0] elemArray,
  output logic [indexBits-1:0]   elemIndex,
  output logic [dataBits-1:0]    operand,
  output logic                   returnOld,    // Old value, not the update
  output logic                   directValid,  // Result needs no element
  output logic [dataBits-1:0]    directValue,
  output errorT                  checkError
);

  logic [arrays-1:0]      allocated;            // Live arrays
  logic [sizeBits-1:0]    sizes [arrays];       // Size of each array
  logic                   canAllocate;
  logic [addressBits-1:0] nextArray;
  logic [countBits-1:0]   newCount;
  logic                   allocate;
  logic                   releaseReq;

  logic [sizeBits-1:0]    curSize;
  errorT                  err;
  logic                   known;                // Action code decoded
  logic                   rmwAction;
  elemOpT                 op;
  logic [indexBits-1:0]   slot;
  logic                   pickOld;
  logic                   useDirect;
  logic [dataBits-1:0]    direct;
  logic                   sizeWrite;
  logic [sizeBits-1:0]    nextSize;
  logic [addressBits-1:0] sizeTarget;

  heapAllocator heap_i (
    .clock        (clock),
    .reset        (reset),
    .allocate     (allocate),
    .releaseReq   (releaseReq),
    .releaseArray (array),
    .canAllocate  (canAllocate),
    .nextArray    (nextArray),
    .newCount     (newCount)
  );

  assign curSize    = sizes[array];
  assign rmwAction  = action inside {actAdd, actAddAfter, actSubtract, actSubAfter,
                                     actOr, actXor, actAnd};
  assign sizeTarget = (action == actAlloc) ? nextArray : array;
  assign allocate   = start && err == errNone && action == actAlloc;
  assign releaseReq = start && err == errNone && action == actFree;

  //--------------------------------------------------------------------------
  // Decode and legality
  //--------------------------------------------------------------------------
  always_comb begin
    known     = 1'b1;
    op        = opNone;
    slot      = index;
    pickOld   = 1'b0;
    useDirect = 1'b0;
    direct    = '0;                             // Inc, Dec, Resize, Free
    sizeWrite = 1'b0;
    nextSize  = curSize;
    case (action)
      actWrite: begin
        op        = opStore;
        sizeWrite = sizeBits'(index) >= curSize;  // Grow past the end
        nextSize  = sizeBits'(index) + 1'b1;
      end
      actRead:     begin op = opLoad;  pickOld = 1'b1; end
      actSize:     begin useDirect = 1'b1; direct = dataBits'(curSize); end
      actInc:      begin useDirect = 1'b1; sizeWrite = 1'b1; nextSize = curSize + 1'b1; end
      actDec:      begin useDirect = 1'b1; sizeWrite = 1'b1; nextSize = curSize - 1'b1; end
      actPush: begin
        op        = opStore;
        slot      = curSize[indexBits-1:0];     // Old size is the slot
        sizeWrite = 1'b1;
        nextSize  = curSize + 1'b1;
      end
      actPop: begin
        op        = opLoad;
        pickOld   = 1'b1;
        sizeWrite = 1'b1;
        nextSize  = curSize - 1'b1;
        slot      = nextSize[indexBits-1:0];    // New size is the slot
      end
      actResize:   begin useDirect = 1'b1; sizeWrite = 1'b1; nextSize = dataIn[sizeBits-1:0]; end
      actAlloc: begin
        useDirect = 1'b1;
        direct    = dataBits'(nextArray);
        sizeWrite = 1'b1;
        nextSize  = '0;                         // Starts empty
      end
      actFree:     useDirect = 1'b1;
      actAdd:      op = opAdd;
      actAddAfter: begin op = opAdd; pickOld = 1'b1; end
      actSubtract: op = opSub;
      actSubAfter: begin op = opSub; pickOld = 1'b1; end
      actOr:       op = opOr;
      actXor:      op = opXor;
      actAnd:      op = opAnd;
      default:     known = 1'b0;
    endcase

    err = errNone;                              // First failing check wins
    if (action != actAlloc && {1'b0, array} >= newCount) err = errNotAllocated;
    else if (action != actAlloc && !allocated[array]) err = errFreed;
    else if ((action == actRead || rmwAction) && sizeBits'(index) >= curSize)
      err = errBounds;
    else if ((action == actInc || action == actPush) && curSize == sizeBits'(arrayLength))
      err = errFull;
    else if ((action == actDec || action == actPop) && curSize == '0) err = errEmpty;
    else if (action == actResize && dataIn > dataBits'(arrayLength)) err = errBounds;
    else if (action == actAlloc && !canAllocate) err = errOutOfMemory;
    else if (!known) err = errBadAction;
  end

  //--------------------------------------------------------------------------
  // Tables and stage register
  //--------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocated <= '0;
      opValid   <= 1'b0;
      for (int a = 0; a < arrays; a++) sizes[a] <= '0;
    end else begin
      opValid <= start;
      if (start && err == errNone) begin
        if (sizeWrite) sizes[sizeTarget] <= nextSize;
        if (action == actAlloc) allocated[nextArray] <= 1'b1;
        if (action == actFree) allocated[array] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    elemOp      <= (err == errNone) ? op : opNone;  // No element change on error
    elemArray   <= array;
    elemIndex   <= slot;
    operand     <= dataIn;
    returnOld   <= pickOld;
    directValid <= useDirect && err == errNone;
    directValue <= direct;
    checkError  <= err;
  end

  // Allocator never hands out an array that is still live
  assert property (@(posedge clock) disable iff (reset) allocate |-> !allocated[nextArray]);

  for (genvar g = 0; g < arrays; g++) begin : gSizeCheck
    assert property (@(posedge clock) disable iff (reset) sizes[g] <= sizeBits'(arrayLength));
  end

endmodule

// ==== rtl/elementStage.sv ====
// Stage 2 of the array memory. Holds the element words, applies the
// read-modify-write operation, and registers the result with done.
`timescale 1ns/1ns

module elementStage import arrayPkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   opValid,
  input  elemOpT                 elemOp,
  input  logic [addressBits-1:0] elemArray,
  input  logic [indexBits-1:0]   elemIndex,
  input  logic [dataBits-1:0]    operand,
  input  logic                   returnOld,
  input  logic                   directValid,
  input  logic [dataBits-1:0]    directValue,
  input  errorT                  checkError,
  output logic                   done,
  output logic [dataBits-1:0]    dataOut,
  output errorT                  error
);

  logic [dataBits-1:0]              storage [slots];  // All arrays, fixed blocks
  logic [addressBits+indexBits-1:0] slot;
  logic [dataBits-1:0]              oldValue;
  logic [dataBits-1:0]              newValue;
  logic                             writeBack;

  assign slot      = {elemArray, elemIndex};
  assign oldValue  = storage[slot];                     // Same-cycle read
  assign writeBack = opValid && elemOp != opNone && elemOp != opLoad;

  always_comb begin
    case (elemOp)
      opStore: newValue = operand;
      opAdd:   newValue = oldValue + operand;
      opSub:   newValue = oldValue - operand;
      opOr:    newValue = oldValue | operand;
      opXor:   newValue = oldValue ^ operand;
      opAnd:   newValue = oldValue & operand;
      default: newValue = oldValue;                     // Load or nothing
    endcase
  end

  //--------------------------------------------------------------------------
  // Storage and result register
  //--------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
      for (int s = 0; s < slots; s++) storage[s] <= '0;  // Elements start at zero
    end else begin
      done <= opValid;
      if (writeBack) storage[slot] <= newValue;         // Visible to next op
    end
  end

  always_ff @(posedge clock) begin
    error <= checkError;
    if (checkError != errNone) dataOut <= '0;
    else if (directValid) dataOut <= directValue;       // Size, array number
    else if (returnOld) dataOut <= oldValue;
    else dataOut <= newValue;
  end

  // Both pipeline stages are cleared, so done stays low for two cycles
  assert property (@(posedge clock) reset |=> !done ##1 !done);

endmodule

// ==== rtl/arrayMemory.sv ====
// Top of the pipelined array heap. A start pulse with an action is answered
// two clock edges later by a one-cycle done with dataOut and error.
`timescale 1ns/1ns

module arrayMemory import arrayPkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start,
  input  actionT                 action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  output logic                   done,
  output logic [dataBits-1:0]    dataOut,
  output errorT                  error
);

  logic                   opValid;       // Stage 1 to stage 2
  elemOpT                 elemOp;
  logic [addressBits-1:0] elemArray;
  logic [indexBits-1:0]   elemIndex;
  logic [dataBits-1:0]    operand;
  logic                   returnOld;
  logic                   directValid;
  logic [dataBits-1:0]    directValue;
  errorT                  checkError;

  requestCheck check_i (
    .clock       (clock),
    .reset       (reset),
    .start       (start),
    .action      (action),
    .array       (array),
    .index       (index),
    .dataIn      (dataIn),
    .opValid     (opValid),
    .elemOp      (elemOp),
    .elemArray   (elemArray),
    .elemIndex   (elemIndex),
    .operand     (operand),
    .returnOld   (returnOld),
    .directValid (directValid),
    .directValue (directValue),
    .checkError  (checkError)
  );

  elementStage element_i (
    .clock       (clock),
    .reset       (reset),
    .opValid     (opValid),
    .elemOp      (elemOp),
    .elemArray   (elemArray),
    .elemIndex   (elemIndex),
    .operand     (operand),
    .returnOld   (returnOld),
    .directValid (directValid),
    .directValue (directValue),
    .checkError  (checkError),
    .done        (done),
    .dataOut     (dataOut),
    .error       (error)
  );

endmodule

// ==== tests/arrayMemoryTb.sv ====
// Self-checking testbench for the array memory pipeline. Directed tests, then
// a seeded random mix, all compared against a reference model in this file.
`timescale 1ns/1ns

module arrayMemoryTb import arrayPkg::*; ();

  localparam int directedRequests = 100;  // Upper bound for the directed tests
  localparam int randomRequests   = 300;
  localparam int watchdogCycles   = 40 * (directedRequests + randomRequests) + 200;

  logic                   clock = 1'b0;
  logic                   reset;
  logic                   start;
  actionT                 action;
  logic [addressBits-1:0] array;
  logic [indexBits-1:0]   index;
  logic [dataBits-1:0]    dataIn;
  logic                   done;
  logic [dataBits-1:0]    dataOut;
  errorT                  error;

  logic [dataBits-1:0] expData [$];       // Expected results, oldest first
  errorT               expErr [$];
  int                  expCycle [$];      // Edge count at which done is seen
  int                  cycleCount;
  int                  checkCount = 0;
  int                  errorCount = 0;
  int                  testErrors = 0;    // errorCount when the test began
  int                  testCount = 0;
  int                  testsFailed = 0;

  int                  modelCount;        // Arrays ever handed out
  bit                  modelLive [arrays];
  int                  modelSize [arrays];
  int                  modelFreed [$];    // Freed arrays, newest at back
  logic [dataBits-1:0] modelMem [arrays][arrayLength];

  // Read-modify-write codes sit last, at 10 to 16
  logic [7:0] legalCodes [17] = '{actWrite, actRead, actSize, actInc, actDec, actPush, actPop,
                                  actResize, actAlloc, actFree, actAdd, actAddAfter, actSubtract,
                                  actSubAfter, actOr, actXor, actAnd};
  logic [7:0] badCodes [5] = '{8'd0, 8'd7, 8'd16, 8'd27, 8'd200};

  arrayMemory dut_i (.*);

  always #10 clock = ~clock;  // 20 ns period

  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] want);
    checkCount++;
    if (got !== want) begin
      errorCount++;
      $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  //--------------------------------------------------------------------------
  // Reference model, one request at a time in issue order
  //--------------------------------------------------------------------------
  task automatic predict(input logic [7:0] code, input int a, input int i,
                         input logic [dataBits-1:0] data,
                         output logic [dataBits-1:0] res, output errorT err);
    logic [dataBits-1:0] old;
    bit                  rmw;
    bit                  known;
    int                  n;
    rmw   = code inside {actAdd, actAddAfter, actSubtract, actSubAfter, actOr, actXor, actAnd};
    known = rmw || code inside {actWrite, actRead, actSize, actInc, actDec, actPush, actPop,
                                actResize, actAlloc, actFree};
    res = '0;
    err = errNone;
    if (code != actAlloc && a >= modelCount) err = errNotAllocated;
    else if (code != actAlloc && !modelLive[a]) err = errFreed;
    else if ((code == actRead || rmw) && i >= modelSize[a]) err = errBounds;
    else if ((code == actInc || code == actPush) && modelSize[a] == arrayLength) err = errFull;
    else if ((code == actDec || code == actPop) && modelSize[a] == 0) err = errEmpty;
    else if (code == actResize && data > dataBits'(arrayLength)) err = errBounds;
    else if (code == actAlloc && modelFreed.size() == 0 && modelCount == arrays)
      err = errOutOfMemory;
    else if (!known) err = errBadAction;
    if (err != errNone) return;                 // Nothing changes on error
    old = modelMem[a][i];
    case (code)
      actWrite: begin
        modelMem[a][i] = data;
        if (i >= modelSize[a]) modelSize[a] = i + 1;
        res = data;
      end
      actRead:   res = old;
      actSize:   res = dataBits'(modelSize[a]);
      actInc:    modelSize[a]++;
      actDec:    modelSize[a]--;
      actPush: begin
        modelMem[a][modelSize[a]] = data;        // Slot is the old size
        modelSize[a]++;
        res = data;
      end
      actPop: begin
        modelSize[a]--;
        res = modelMem[a][modelSize[a]];         // Slot is the new size
      end
      actResize: modelSize[a] = int'(data);
      actAlloc: begin
        if (modelFreed.size() != 0) n = modelFreed.pop_back();  // Reuse newest freed
        else begin
          n = modelCount;
          modelCount++;
        end
        modelLive[n] = 1'b1;
        modelSize[n] = 0;
        res = dataBits'(n);
      end
      actFree: begin
        modelLive[a] = 1'b0;
        modelFreed.push_back(a);
      end
      actAdd, actAddAfter:      modelMem[a][i] = old + data;
      actSubtract, actSubAfter: modelMem[a][i] = old - data;
      actOr:                    modelMem[a][i] = old | data;
      actXor:                   modelMem[a][i] = old ^ data;
      actAnd:                   modelMem[a][i] = old & data;
      default: ;
    endcase
    if (rmw) res = (code == actAddAfter || code == actSubAfter) ? old : modelMem[a][i];
  endtask

  task automatic issue(input logic [7:0] code, input int a, input int i,
                       input logic [dataBits-1:0] data);
    logic [dataBits-1:0] res;
    errorT               err;
    predict(code, a, i, data, res, err);
    @(posedge clock);
    start  <= 1'b1;
    action <= actionT'(code);
    array  <= addressBits'(a);
    index  <= indexBits'(i);
    dataIn <= data;
    expData.push_back(res);
    expErr.push_back(err);
    expCycle.push_back(cycleCount + 3);          // Sampled next edge, done seen two later
  endtask

  task automatic finishTest(input string name);
    int errs;
    @(posedge clock);
    start <= 1'b0;
    while (expData.size() != 0) @(negedge clock);  // Drain the pipeline
    errs = errorCount - testErrors;
    testErrors = errorCount;
    testCount++;
    if (errs != 0) testsFailed++;
    $display("Test %0d %s: %s, %0d errors", testCount, name, (errs == 0) ? "passed" : "failed",
             errs);
  endtask

  // Result checker, one expected entry per done pulse
  always @(posedge clock) begin
    if (reset) cycleCount <= 0;
    else cycleCount <= cycleCount + 1;
    if (!reset && done) begin
      if (expData.size() == 0) begin
        errorCount++;
        $display("Unexpected done at %0t ns with no request outstanding", $time);
      end else begin
        checkValue("dataOut", 32'(dataOut), 32'(expData.pop_front()));
        checkValue("error", 32'(error), 32'(expErr.pop_front()));
        checkValue("done cycle", 32'(cycleCount), 32'(expCycle.pop_front()));
      end
    end
  end

  initial begin : watchdog
    repeat (watchdogCycles) @(posedge clock);
    $display("Timeout: run did not finish within %0d cycles", watchdogCycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------
  initial begin : stimulus
    logic [7:0]          code;
    logic [dataBits-1:0] data;
    int                  pick;
    void'($urandom(32'hc9af9cf9));
    reset  <= 1'b1;
    start  <= 1'b0;
    action <= actRead;
    array  <= '0;
    index  <= '0;
    dataIn <= '0;
    modelCount = 0;
    for (int a = 0; a < arrays; a++) begin
      modelLive[a] = 1'b0;
      modelSize[a] = 0;
      for (int i = 0; i < arrayLength; i++) modelMem[a][i] = '0;  // Storage clears on reset
    end
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    repeat (4) issue(actAlloc, 0, 0, '0);        // Arrays 0 to 3 from the counter
    issue(actFree, 1, 0, '0);
    issue(actAlloc, 0, 0, '0);                   // Array 1 back from the stack
    finishTest("alloc and free");

    issue(actWrite, 0, 2, 16'h1234);
    issue(actWrite, 0, 5, 16'hbeef);
    issue(actRead, 0, 2, '0);
    issue(actRead, 0, 5, '0);
    issue(actSize, 0, 0, '0);
    issue(actWrite, 0, 1, 16'h0042);             // Below the end, size kept
    issue(actSize, 0, 0, '0);
    finishTest("write read size");

    for (int k = 0; k < arrayLength; k++) issue(actPush, 2, 0, dataBits'(16'h0100 + k));
    issue(actPush, 2, 0, 16'hdead);              // Full
    issue(actInc, 2, 0, '0);
    repeat (arrayLength) issue(actPop, 2, 0, '0);  // Last in, first out
    issue(actPop, 2, 0, '0);                     // Empty
    issue(actDec, 2, 0, '0);
    issue(actInc, 2, 0, '0);
    issue(actInc, 2, 0, '0);
    issue(actDec, 2, 0, '0);
    issue(actSize, 2, 0, '0);
    issue(actResize, 2, 0, 16'd6);
    issue(actSize, 2, 0, '0);
    issue(actResize, 2, 0, 16'd9);               // Past arrayLength
    issue(actRead, 2, 5, '0);                    // Old contents show again
    finishTest("stack and size");

    issue(actWrite, 3, 4, 16'h00f0);
    for (int k = 10; k < 17; k++) begin
      issue(legalCodes[k], 3, 4, dataBits'(16'h0135 * (k - 9)));
      issue(actRead, 3, 4, '0);
    end
    finishTest("read-modify-write");

    issue(actRead, 6, 0, '0);                    // Never handed out
    issue(actFree, 3, 0, '0);
    issue(actWrite, 3, 0, 16'h0001);             // Freed
    issue(actFree, 3, 0, '0);                    // Double free
    issue(actRead, 0, 7, '0);                    // Past the size
    repeat (5) issue(actAlloc, 0, 0, '0);        // Arrays 3 to 7
    issue(actAlloc, 0, 0, '0);                   // Ninth
    issue(8'd7, 0, 0, '0);
    issue(8'd200, 1, 0, '0);
    finishTest("error codes");

    for (int n = 0; n < randomRequests; n++) begin
      if ($urandom % 100 < 8) begin
        pick = int'($urandom % 5);
        code = badCodes[pick];
      end else begin
        pick = int'($urandom % 17);
        code = legalCodes[pick];
      end
      data = (code == actResize) ? dataBits'($urandom % 11) : dataBits'($urandom);
      issue(code, int'($urandom % arrays), int'($urandom % arrayLength), data);
    end
    finishTest("random mix");

    $display("%0d tests, %0d failed, %0d checks, %0d errors", testCount, testsFailed,
             checkCount, errorCount);
    if (errorCount == 0) $display("SIMULATION PASSED");
    else $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
rtl/arrayPkg.sv
rtl/heapAllocator.sv
rtl/requestCheck.sv
rtl/elementStage.sv
rtl/arrayMemory.sv
tests/arrayMemoryTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -f sim.f --top-module arrayMemoryTb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VarrayMemoryTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation run exited with status $status"
  exit 1
fi

if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "Pass message missing from sim.log"
  exit 1
fi
exit 0
